//--- console_usb_defines.svh
`ifndef CONSOLE_USB_DEFINES_SVH
`define CONSOLE_USB_DEFINES_SVH

// Devices that each report a two-bit size code in dev_stat
`define CONSOLE_NUM_DEV 8

// Length contribution per size code
`define CONSOLE_LEN_SZ0 12'h000
`define CONSOLE_LEN_SZ1 12'h080
`define CONSOLE_LEN_SZ2 12'h100
`define CONSOLE_LEN_SZ3 12'h200

// Bag type codes carried in the top nibble of a command word
`define CONSOLE_BTYPE_DATA 4'b0101
`define CONSOLE_BTYPE_STAT 4'b0011

// Length log geometry
`define CONSOLE_LOG_DEPTH 16
`define CONSOLE_LOG_AW 4

`endif

//--- console_usb_pkg.sv
package console_usb_pkg;

    // Device size update
    typedef struct packed {
        logic [3:0] btype;
        logic [2:0] dev;
        logic [1:0] code;
        logic [6:0] pad;
    } stat_view_t;

    // Bag read open or close
    typedef struct packed {
        logic [3:0]  btype;
        logic        open;
        logic [10:0] pad;
    } read_view_t;

    // One host word read through whichever view its btype selects
    typedef union packed {
        stat_view_t stat_view;
        read_view_t read_view;
    } cmd_word_u;

    // Length log write request
    typedef struct packed {
        logic        valid;
        logic [12:0] len;
    } log_wr_t;

    // One-hot bag engine states
    typedef enum logic [4:0] {
        IDLE = 5'b00001,
        WAIT = 5'b00010,
        WORK = 5'b00100,
        DONE = 5'b01000,
        MAKE = 5'b10000
    } bag_state_e;

endpackage

//--- console_cmd_dec.sv
`timescale 1ns/1ps
`include "console_usb_defines.svh"

module console_cmd_dec
    import console_usb_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           cmd_valid,
    input  cmd_word_u                      cmd_word,

    output logic [2*`CONSOLE_NUM_DEV-1:0]  dev_stat,
    output logic                           fd_read,
    output logic [3:0]                     read_btype
);

    logic is_stat;
    logic stat_wr;
    logic read_wr;

    // The btype nibble sits in the same place in both views
    assign is_stat = (cmd_word.stat_view.btype == `CONSOLE_BTYPE_STAT);

    assign stat_wr = cmd_valid && is_stat;
    assign read_wr = cmd_valid && !is_stat;

    // Device size codes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_stat <= '0;
        end else if (stat_wr) begin
            // Device 0 owns the top two bits
            for (int d = 0; d < `CONSOLE_NUM_DEV; d++) begin
                if (cmd_word.stat_view.dev == 3'(d)) begin
                    dev_stat[2*(`CONSOLE_NUM_DEV-1-d) +: 2] <= cmd_word.stat_view.code;
                end
            end
        end
    end

    // Read open level and the bag type it was opened with
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_read    <= 1'b0;
            read_btype <= 4'h0;
        end else if (read_wr) begin
            fd_read    <= cmd_word.read_view.open;
            read_btype <= cmd_word.read_view.btype;
        end
    end

    // Host strobe must be driven once reset is released
    a_cmd_valid_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(cmd_valid)
    ) else $error("cmd_valid is unknown");

endmodule

//--- console_usb_num.sv
`timescale 1ns/1ps
`include "console_usb_defines.svh"

module console_usb_num
    import console_usb_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic [2*`CONSOLE_NUM_DEV-1:0]  dev_stat,
    input  logic                           fd_read,
    input  logic [3:0]                     read_btype,

    output logic [12:0]                    data_len,
    output log_wr_t                        log_wr
);

    bag_state_e  state;
    bag_state_e  next_state;

    logic [11:0] contrib [`CONSOLE_NUM_DEV];
    logic [12:0] len_sum;
    logic        wr_valid;

    function automatic logic [11:0] size_to_len(input logic [1:0] code);
        case (code)
            2'd0:    return `CONSOLE_LEN_SZ0;
            2'd1:    return `CONSOLE_LEN_SZ1;
            2'd2:    return `CONSOLE_LEN_SZ2;
            default: return `CONSOLE_LEN_SZ3;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                if (fd_read && read_btype == `CONSOLE_BTYPE_DATA) begin
                    next_state = MAKE;
                end else begin
                    next_state = WAIT;
                end
            end
            MAKE: next_state = WORK;
            WORK: next_state = DONE;
            // Hold until the host closes the read
            DONE: next_state = fd_read ? DONE : WAIT;
            default: next_state = IDLE;
        endcase
    end

    // Per device contribution with device 0 taken from the top slot
    always_ff @(posedge clk) begin
        if (state == MAKE) begin
            for (int i = 0; i < `CONSOLE_NUM_DEV; i++) begin
                contrib[i] <= size_to_len(dev_stat[2*(`CONSOLE_NUM_DEV-1-i) +: 2]);
            end
        end
    end

    always_comb begin
        len_sum = '0;
        for (int i = 0; i < `CONSOLE_NUM_DEV; i++) begin
            len_sum = len_sum + {1'b0, contrib[i]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_len <= '0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= (state == WORK);
            if (state == WORK) begin
                data_len <= len_sum;
            end
        end
    end

    // One log entry per computed length
    assign log_wr = '{valid: wr_valid, len: data_len};

    a_state_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(state)
    ) else $error("bag state not one-hot: %b", state);

endmodule

//--- console_len_log.sv
`timescale 1ns/1ps
`include "console_usb_defines.svh"

module console_len_log
    import console_usb_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  log_wr_t                     log_wr,

    input  logic                        rd_valid,
    input  logic [`CONSOLE_LOG_AW-1:0]  rd_addr,
    output logic                        rsp_valid,
    output logic [12:0]                 rsp_len,

    output logic [`CONSOLE_LOG_AW:0]    log_count
);

    logic [12:0]                   mem [`CONSOLE_LOG_DEPTH];
    logic [`CONSOLE_LOG_DEPTH-1:0] filled;
    logic [`CONSOLE_LOG_AW-1:0]    wr_ptr;

    logic                          pend_valid;
    logic [12:0]                   pend_len;
    log_wr_t                       wr_req;
    logic                          wr_grant;

    // A deferred write goes ahead of anything newer
    assign wr_req = pend_valid ? log_wr_t'{valid: 1'b1, len: pend_len} : log_wr;

    // Single memory port where the host read has priority
    assign wr_grant = wr_req.valid && !rd_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= wr_req.valid && rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req.valid && rd_valid) begin
            pend_len <= wr_req.len;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_grant) begin
            mem[wr_ptr] <= wr_req.len;
        end
    end

    // Pointer wraps while the count stops at depth
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            filled    <= '0;
            log_count <= '0;
        end else if (wr_grant) begin
            wr_ptr         <= wr_ptr + 1'b1;
            filled[wr_ptr] <= 1'b1;
            if (log_count != `CONSOLE_LOG_DEPTH) begin
                log_count <= log_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    // Unwritten slots read back as zero
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_len <= filled[rd_addr] ? mem[rd_addr] : 13'h0000;
        end
    end

    // The calculator spaces its requests far enough apart for one deferral
    a_no_wr_over_pend: assert property (
        @(posedge clk) disable iff (rst) pend_valid |-> !log_wr.valid
    ) else $error("log write request arrived while one was pending");

endmodule

//--- console_usb_top.sv
`timescale 1ns/1ps
`include "console_usb_defines.svh"

module console_usb_top
    import console_usb_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        cmd_valid,
    input  cmd_word_u                   cmd_word,

    input  logic                        rd_valid,
    input  logic [`CONSOLE_LOG_AW-1:0]  rd_addr,
    output logic                        rsp_valid,
    output logic [12:0]                 rsp_len,

    output logic [`CONSOLE_LOG_AW:0]    log_count,
    output logic [12:0]                 data_len
);

    logic [2*`CONSOLE_NUM_DEV-1:0] dev_stat;
    logic                          fd_read;
    logic [3:0]                    read_btype;
    log_wr_t                       log_wr;

    console_cmd_dec i_cmd_dec (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .dev_stat   (dev_stat),
        .fd_read    (fd_read),
        .read_btype (read_btype)
    );

    console_usb_num i_usb_num (
        .clk        (clk),
        .rst        (rst),
        .dev_stat   (dev_stat),
        .fd_read    (fd_read),
        .read_btype (read_btype),
        .data_len   (data_len),
        .log_wr     (log_wr)
    );

    console_len_log i_len_log (
        .clk        (clk),
        .rst        (rst),
        .log_wr     (log_wr),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rsp_valid  (rsp_valid),
        .rsp_len    (rsp_len),
        .log_count  (log_count)
    );

endmodule

//--- tb_console_usb.sv
`timescale 1ns/1ps
`include "console_usb_defines.svh"

module tb_console_usb
    import console_usb_pkg::*;
();

    localparam int max_ops    = 64;
    localparam int rst_cycles = 3;

    localparam logic [15:0] op_end   = 16'd0;
    localparam logic [15:0] op_cmd   = 16'd1;
    localparam logic [15:0] op_read  = 16'd2;
    localparam logic [15:0] op_idle  = 16'd3;
    localparam logic [15:0] op_check = 16'd4;

    // Length contribution of each size code
    localparam logic [11:0] len_of_code [4] = '{
        `CONSOLE_LEN_SZ0, `CONSOLE_LEN_SZ1, `CONSOLE_LEN_SZ2, `CONSOLE_LEN_SZ3
    };

    logic                        clk;
    logic                        rst;
    logic                        cmd_valid;
    cmd_word_u                   cmd_word;
    logic                        rd_valid;
    logic [`CONSOLE_LOG_AW-1:0]  rd_addr;
    logic                        rsp_valid;
    logic [12:0]                 rsp_len;
    logic [`CONSOLE_LOG_AW:0]    log_count;
    logic [12:0]                 data_len;

    // Three words per operation as op, arg and expected value
    logic [15:0] op_mem [3*max_ops];

    // Reference model state
    logic [1:0]                  ref_code [`CONSOLE_NUM_DEV];
    logic                        ref_done;
    logic [12:0]                 ref_len;
    logic [12:0]                 ref_log [`CONSOLE_LOG_DEPTH];
    logic [`CONSOLE_LOG_AW-1:0]  ref_ptr;
    int                          ref_count;

    int n_tests;
    int n_errors;
    int cycles;
    int cycle_limit = 0;

    console_usb_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rsp_valid  (rsp_valid),
        .rsp_len    (rsp_len),
        .log_count  (log_count),
        .data_len   (data_len)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog armed once the limit is known
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [12:0] model_length();
        logic [12:0] sum;
        sum = '0;
        for (int i = 0; i < `CONSOLE_NUM_DEV; i++) begin
            sum = sum + {1'b0, len_of_code[ref_code[i]]};
        end
        return sum;
    endfunction

    // Mirrors the bag engine and logs a length only when a DATA open finds it idle
    task automatic update_model(input cmd_word_u w);
        if (w.stat_view.btype == `CONSOLE_BTYPE_STAT) begin
            ref_code[w.stat_view.dev] = w.stat_view.code;
        end else if (ref_done) begin
            if (!w.read_view.open) begin
                ref_done = 1'b0;
            end
        end else if (w.read_view.open && w.read_view.btype == `CONSOLE_BTYPE_DATA) begin
            ref_done = 1'b1;
            ref_len = model_length();
            ref_log[ref_ptr] = ref_len;
            ref_ptr = ref_ptr + 1'b1;
            if (ref_count < `CONSOLE_LOG_DEPTH) begin
                ref_count++;
            end
        end
    endtask

    task automatic compare_file(input string what, input logic [15:0] file_val,
                                input logic [15:0] model_val);
        assert (file_val == model_val) else begin
            $display("input file and reference model disagree on %s: file %h, model %h",
                     what, file_val, model_val);
            n_errors++;
        end
    endtask

    task automatic apply_command(input logic [15:0] word, input logic [15:0] file_len);
        cmd_word_u   w;
        logic [12:0] prev_len;
        w = word;
        prev_len = ref_len;
        cmd_valid = 1'b1;
        cmd_word  = w;
        @(negedge clk);
        cmd_valid = 1'b0;
        update_model(w);
        // Old length still holds one cycle before the new one lands
        repeat (2) @(negedge clk);
        assert (data_len == prev_len) else begin
            $display("error: data_len = %h, expected %h", data_len, prev_len);
            n_errors++;
        end
        // New length lands 3 cycles after the strobe
        @(negedge clk);
        compare_file("data_len", file_len, {3'b000, ref_len});
        assert (data_len == ref_len) else begin
            $display("error: data_len = %h, expected %h", data_len, ref_len);
            n_errors++;
        end
    endtask

    task automatic host_read(input logic [15:0] addr, input logic [15:0] file_len);
        logic [12:0] exp_len;
        exp_len  = ref_log[addr[`CONSOLE_LOG_AW-1:0]];
        rd_valid = 1'b1;
        rd_addr  = addr[`CONSOLE_LOG_AW-1:0];
        @(negedge clk);
        rd_valid = 1'b0;
        compare_file("rsp_len", file_len, {3'b000, exp_len});
        assert (rsp_valid) else begin
            $display("no readback response on the cycle after reading address %0d", addr);
            n_errors++;
        end
        assert (rsp_len == exp_len) else begin
            $display("error: rsp_len = %h, expected %h", rsp_len, exp_len);
            n_errors++;
        end
    endtask

    task automatic check_state(input logic [15:0] file_count, input logic [15:0] file_len);
        compare_file("log_count", file_count, 16'(ref_count));
        compare_file("data_len", file_len, {3'b000, ref_len});
        assert (int'(log_count) == ref_count) else begin
            $display("error: log_count = %h, expected %h", log_count, ref_count);
            n_errors++;
        end
        assert (data_len == ref_len) else begin
            $display("error: data_len = %h, expected %h", data_len, ref_len);
            n_errors++;
        end
    endtask

    initial begin
        int          n_ops;
        int          idle_sum;
        int          errs_before;
        logic [15:0] op;
        logic [15:0] arg;
        logic [15:0] val;
        string       kind;

        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        rd_valid  = 1'b0;
        rd_addr   = '0;

        for (int i = 0; i < `CONSOLE_NUM_DEV; i++) begin
            ref_code[i] = 2'b00;
        end
        for (int i = 0; i < `CONSOLE_LOG_DEPTH; i++) begin
            ref_log[i] = 13'h0000;
        end
        ref_done  = 1'b0;
        ref_len   = 13'h0000;
        ref_ptr   = '0;
        ref_count = 0;
        n_tests   = 0;
        n_errors  = 0;

        $readmemh("console_usb_input.txt", op_mem);

        n_ops    = 0;
        idle_sum = 0;
        while (n_ops < max_ops && op_mem[3*n_ops] != op_end) begin
            if (op_mem[3*n_ops] == op_idle) begin
                idle_sum += int'(op_mem[3*n_ops+1]);
            end
            n_ops++;
        end
        // Reset and a little slack on top of the file's own length
        cycle_limit = rst_cycles + idle_sum + 8*n_ops + 8;

        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_ops; i++) begin
            op  = op_mem[3*i];
            arg = op_mem[3*i+1];
            val = op_mem[3*i+2];
            errs_before = n_errors;
            case (op)
                op_cmd: begin
                    kind = "command";
                    apply_command(arg, val);
                end
                op_read: begin
                    kind = "read";
                    host_read(arg, val);
                end
                op_idle: begin
                    kind = "idle";
                    repeat (arg) @(negedge clk);
                end
                op_check: begin
                    kind = "check";
                    check_state(arg, val);
                end
                default: begin
                    kind = "unknown";
                    $display("unknown operation %h on entry %0d of the input file", op, i + 1);
                    n_errors++;
                end
            endcase
            n_tests++;
            $display("test %0d %s %h: %s", i + 1, kind, arg,
                     (n_errors == errs_before) ? "ok" : "FAILED");
        end

        $display("%0d tests run, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- console_usb.f
+incdir+.
console_usb_pkg.sv
console_cmd_dec.sv
console_usb_num.sv
console_len_log.sv
console_usb_top.sv
tb_console_usb.sv

//--- console_usb_input.txt
// op arg exp in hex; op 1 command word, 2 host read of a log address, 3 idle cycles,
// 4 check with arg = log_count; exp is data_len or rsp_len; op 0 ends the list
4 0000 0000
2 0000 0000
// All devices at code 0
1 5800 0000
3 0002 0000
4 0001 0000
1 5000 0000
// All devices at code 3
1 3180 0000
1 3380 0000
1 3580 0000
1 3780 0000
1 3980 0000
1 3b80 0000
1 3d80 0000
1 3f80 0000
1 5800 1000
3 0002 0000
4 0002 1000
// Second open without close is ignored
1 5800 1000
3 0002 0000
4 0002 1000
1 5000 1000
// Non-data bag type
1 9800 1000
3 0002 0000
4 0002 1000
1 9000 1000
// Mixed codes, 0x700 in total
1 3080 1000
1 3300 1000
1 3400 1000
1 3780 1000
1 3880 1000
1 3b00 1000
1 3c00 1000
1 3f80 1000
1 5800 0700
// Read lands on the same cycle as the log write
2 0001 1000
3 0002 0000
4 0003 0700
2 0000 0000
2 0001 1000
2 0002 0700
1 5000 0700
// Device 7 back to code 0
1 3e00 0700
1 5800 0500
3 0002 0000
4 0004 0500
2 0003 0500
0 0000 0000

//--- run_sim.sh
#!/bin/sh
# Build and run the console USB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_console_usb \
        --Mdir "$OBJ" \
        -f console_usb.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_console_usb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
exit 1
